// ==== files.f ====
hdl/rv_ex_pkg.sv
hdl/alu_control.sv
hdl/forwarding_unit.sv
hdl/alu.sv
hdl/store_lane.sv
hdl/jb_unit.sv
hdl/ex.sv
hdl/ex_mem_reg.sv
hdl/ex_stage_top.sv
tb/ex_stage_tb.sv

// ==== hdl/alu.sv ====
// rv32i integer ops only, no mul/div; shift amount is b[4:0]
`timescale 1ns/1ps

module alu (
    input  logic [rv_ex_pkg::WORD_W-1:0] a_i,
    input  logic [rv_ex_pkg::WORD_W-1:0] b_i,
    input  rv_ex_pkg::alu_op_e           fn_i,
    output logic [rv_ex_pkg::WORD_W-1:0] result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = ($signed(a_i) < $signed(b_i));
    assign lt_unsigned = (a_i < b_i);

    always_comb begin
        case (fn_i)
            rv_ex_pkg::ADD: begin
                result_o = a_i + b_i;
            end
            rv_ex_pkg::SUB: begin
                result_o = a_i - b_i;
            end
            rv_ex_pkg::SLL: begin
                result_o = a_i << shamt;
            end
            rv_ex_pkg::SLT: begin
                result_o = {{(rv_ex_pkg::WORD_W-1){1'b0}}, lt_signed};
            end
            rv_ex_pkg::SLTU: begin
                result_o = {{(rv_ex_pkg::WORD_W-1){1'b0}}, lt_unsigned};
            end
            rv_ex_pkg::XOR: begin
                result_o = a_i ^ b_i;
            end
            rv_ex_pkg::SRL: begin
                result_o = a_i >> shamt;
            end
            rv_ex_pkg::SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            rv_ex_pkg::OR: begin
                result_o = a_i | b_i;
            end
            rv_ex_pkg::AND: begin
                result_o = a_i & b_i;
            end
            rv_ex_pkg::PASS_B: begin
                result_o = b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/alu_control.sv ====
// class 00 is add and 01 is pass b; funct3 and bit 30 are only decoded for classes 10 and 11
`timescale 1ns/1ps

module alu_control (
    input  logic [1:0]          alu_op_i,
    input  logic [2:0]          funct3_i,
    input  logic                inst30_i,
    output rv_ex_pkg::alu_op_e  alu_fn_o
);

    localparam logic [1:0] CLS_ADD    = 2'b00;
    localparam logic [1:0] CLS_PASS_B = 2'b01;
    localparam logic [1:0] CLS_R      = 2'b10;

    logic is_r_type;

    assign is_r_type = (alu_op_i == CLS_R);

    always_comb begin
        case (alu_op_i)
            CLS_ADD: begin
                alu_fn_o = rv_ex_pkg::ADD;
            end
            CLS_PASS_B: begin
                alu_fn_o = rv_ex_pkg::PASS_B;
            end
            default: begin
                // r-type and i-type share the funct3 map
                case (funct3_i)
                    3'b000: begin
                        // addi has no sub form
                        if (is_r_type && inst30_i) begin
                            alu_fn_o = rv_ex_pkg::SUB;
                        end else begin
                            alu_fn_o = rv_ex_pkg::ADD;
                        end
                    end
                    3'b001:  alu_fn_o = rv_ex_pkg::SLL;
                    3'b010:  alu_fn_o = rv_ex_pkg::SLT;
                    3'b011:  alu_fn_o = rv_ex_pkg::SLTU;
                    3'b100:  alu_fn_o = rv_ex_pkg::XOR;
                    3'b101: begin
                        if (inst30_i) begin
                            alu_fn_o = rv_ex_pkg::SRA;
                        end else begin
                            alu_fn_o = rv_ex_pkg::SRL;
                        end
                    end
                    3'b110:  alu_fn_o = rv_ex_pkg::OR;
                    default: alu_fn_o = rv_ex_pkg::AND;
                endcase
            end
        endcase
    end

endmodule

// ==== hdl/ex.sv ====
// purely combinational; forwarding covers the write-back stage only
`timescale 1ns/1ps

module ex (
    input  rv_ex_pkg::ex_req_t           req_i,
    input  rv_ex_pkg::wb_fwd_t           fwd_i,
    input  logic                         stall_i,
    output rv_ex_pkg::ex_mem_t           ex_next_o,
    output logic                         redirect_o,
    output logic [rv_ex_pkg::WORD_W-1:0] redirect_pc_o
);

    rv_ex_pkg::alu_op_e           alu_fn;
    rv_ex_pkg::fwd_sel_e          reg1_sel;
    rv_ex_pkg::fwd_sel_e          reg2_sel;
    logic                         reg1_fwd;
    logic                         reg2_fwd;
    logic [rv_ex_pkg::WORD_W-1:0] rs1_val;
    logic [rv_ex_pkg::WORD_W-1:0] rs2_val;
    logic [rv_ex_pkg::WORD_W-1:0] op_a;
    logic [rv_ex_pkg::WORD_W-1:0] op_b;
    logic [rv_ex_pkg::WORD_W-1:0] alu_result;
    logic [rv_ex_pkg::WORD_W-1:0] csr_data;
    logic [rv_ex_pkg::WORD_W-1:0] st_wdata;
    logic [3:0]                   st_we;
    logic                         st_misalign;
    logic                         jb_redirect;

    alu_control u_alu_control (
        .alu_op_i (req_i.ctrl.alu_op),
        .funct3_i (req_i.funct3),
        .inst30_i (req_i.inst30),
        .alu_fn_o (alu_fn)
    );

    forwarding_unit u_forwarding_unit (
        .reg1_addr_i (req_i.reg1_addr),
        .reg2_addr_i (req_i.reg2_addr),
        .op1_pc_i    (req_i.ctrl.op1_pc),
        .op2_imm_i   (req_i.ctrl.op2_imm),
        .fwd_i       (fwd_i),
        .reg1_sel_o  (reg1_sel),
        .reg2_sel_o  (reg2_sel),
        .reg1_fwd_o  (reg1_fwd),
        .reg2_fwd_o  (reg2_fwd)
    );

    // register values after forwarding
    assign rs1_val = reg1_fwd ? fwd_i.data : req_i.reg1_data;
    assign rs2_val = reg2_fwd ? fwd_i.data : req_i.reg2_data;

    always_comb begin
        case (reg1_sel)
            rv_ex_pkg::WB:        op_a = fwd_i.data;
            rv_ex_pkg::PC_OR_IMM: op_a = req_i.pc;
            default:              op_a = req_i.reg1_data;
        endcase
        case (reg2_sel)
            rv_ex_pkg::WB:        op_b = fwd_i.data;
            rv_ex_pkg::PC_OR_IMM: op_b = req_i.imm;
            default:              op_b = req_i.reg2_data;
        endcase
    end

    alu u_alu (
        .a_i      (op_a),
        .b_i      (op_b),
        .fn_i     (alu_fn),
        .result_o (alu_result)
    );

    store_lane u_store_lane (
        .store_i    (req_i.ctrl.dmem_store),
        .funct3_i   (req_i.funct3),
        .addr_lo_i  (alu_result[1:0]),
        .data_i     (rs2_val),
        .we_o       (st_we),
        .wdata_o    (st_wdata),
        .misalign_o (st_misalign)
    );

    jb_unit u_jb_unit (
        .jump_i       (req_i.ctrl.jump),
        .funct3_i     (req_i.funct3),
        .rs1_i        (rs1_val),
        .rs2_i        (rs2_val),
        .pc_i         (req_i.pc),
        .imm_i        (req_i.imm),
        .alu_result_i (alu_result),
        .redirect_o   (jb_redirect),
        .target_o     (redirect_pc_o)
    );

    // csrrw takes rs1, csrrwi takes the zimm carried in imm
    always_comb begin
        case (req_i.funct3)
            3'b001:  csr_data = rs1_val;
            3'b101:  csr_data = req_i.imm;
            default: csr_data = '0;
        endcase
    end

    assign redirect_o = jb_redirect && req_i.valid && !stall_i;

    always_comb begin
        ex_next_o.valid          = req_i.valid;
        ex_next_o.alu_result     = alu_result;
        ex_next_o.mem_wdata      = st_wdata;
        ex_next_o.dmem_we        = st_we;
        ex_next_o.store_misalign = st_misalign;
        ex_next_o.wb_addr        = req_i.wb_addr;
        ex_next_o.wr_mux         = req_i.ctrl.wr_mux;
        ex_next_o.pc_plus        = req_i.pc_plus;
        ex_next_o.csr_we         = req_i.ctrl.csr_we;
        ex_next_o.csr_data       = csr_data;
    end

endmodule

// ==== hdl/ex_mem_reg.sv ====
// holds while stall_i is high; a bubble keeps its payload but loses all side effects
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               stall_i,
    input  rv_ex_pkg::ex_mem_t d_i,
    output rv_ex_pkg::ex_mem_t q_o
);

    rv_ex_pkg::ex_mem_t d_gated;

    always_comb begin
        d_gated = d_i;
        if (!d_i.valid) begin
            d_gated.dmem_we        = 4'b0000;
            d_gated.store_misalign = 1'b0;
            d_gated.csr_we         = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_gated;
        end
    end

    // store_lane must suppress enables on a misaligned access
    a_misalign_no_we: assert property (@(posedge clk) disable iff (!rst_n_i)
        q_o.store_misalign |-> (q_o.dmem_we == 4'b0000));

    a_no_x_out: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(q_o));

endmodule

// ==== hdl/ex_stage_top.sv ====
// redirect outputs are combinational from req_i and fwd_i, ex_mem_o lags by one cycle
`timescale 1ns/1ps

module ex_stage_top (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         stall_i,
    input  rv_ex_pkg::ex_req_t           req_i,
    input  rv_ex_pkg::wb_fwd_t           fwd_i,
    output rv_ex_pkg::ex_mem_t           ex_mem_o,
    output logic                         redirect_o,
    output logic [rv_ex_pkg::WORD_W-1:0] redirect_pc_o
);

    rv_ex_pkg::ex_mem_t ex_next;

    ex u_ex (
        .req_i         (req_i),
        .fwd_i         (fwd_i),
        .stall_i       (stall_i),
        .ex_next_o     (ex_next),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .d_i     (ex_next),
        .q_o     (ex_mem_o)
    );

endmodule

// ==== hdl/forwarding_unit.sv ====
// only the write-back stage is a forwarding source and x0 is never forwarded
`timescale 1ns/1ps

module forwarding_unit (
    input  logic [rv_ex_pkg::REG_ADDR_W-1:0] reg1_addr_i,
    input  logic [rv_ex_pkg::REG_ADDR_W-1:0] reg2_addr_i,
    input  logic                             op1_pc_i,
    input  logic                             op2_imm_i,
    input  rv_ex_pkg::wb_fwd_t               fwd_i,
    output rv_ex_pkg::fwd_sel_e              reg1_sel_o,
    output rv_ex_pkg::fwd_sel_e              reg2_sel_o,
    output logic                             reg1_fwd_o,
    output logic                             reg2_fwd_o
);

    // raw register replacement, used by branch and store data
    assign reg1_fwd_o = fwd_i.we && (reg1_addr_i == fwd_i.addr) && (reg1_addr_i != '0);
    assign reg2_fwd_o = fwd_i.we && (reg2_addr_i == fwd_i.addr) && (reg2_addr_i != '0);

    // pc and imm win over forwarding
    always_comb begin
        if (op1_pc_i) begin
            reg1_sel_o = rv_ex_pkg::PC_OR_IMM;
        end else if (reg1_fwd_o) begin
            reg1_sel_o = rv_ex_pkg::WB;
        end else begin
            reg1_sel_o = rv_ex_pkg::REG;
        end
    end

    always_comb begin
        if (op2_imm_i) begin
            reg2_sel_o = rv_ex_pkg::PC_OR_IMM;
        end else if (reg2_fwd_o) begin
            reg2_sel_o = rv_ex_pkg::WB;
        end else begin
            reg2_sel_o = rv_ex_pkg::REG;
        end
    end

endmodule

// ==== hdl/jb_unit.sv ====
// redirect is raw here and gets qualified by valid and stall in ex
`timescale 1ns/1ps

module jb_unit (
    input  logic [1:0]                   jump_i,
    input  logic [2:0]                   funct3_i,
    input  logic [rv_ex_pkg::WORD_W-1:0] rs1_i,
    input  logic [rv_ex_pkg::WORD_W-1:0] rs2_i,
    input  logic [rv_ex_pkg::WORD_W-1:0] pc_i,
    input  logic [rv_ex_pkg::WORD_W-1:0] imm_i,
    input  logic [rv_ex_pkg::WORD_W-1:0] alu_result_i,
    output logic                         redirect_o,
    output logic [rv_ex_pkg::WORD_W-1:0] target_o
);

    localparam logic [1:0] JUMP_BRANCH = 2'b01;
    localparam logic [1:0] JUMP_JAL    = 2'b10;
    localparam logic [1:0] JUMP_JALR   = 2'b11;

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    assign eq  = (rs1_i == rs2_i);
    assign lt  = ($signed(rs1_i) < $signed(rs2_i));
    assign ltu = (rs1_i < rs2_i);

    always_comb begin
        case (funct3_i)
            3'b000:  taken = eq;
            3'b001:  taken = !eq;
            3'b100:  taken = lt;
            3'b101:  taken = !lt;
            3'b110:  taken = ltu;
            3'b111:  taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (jump_i)
            JUMP_BRANCH: redirect_o = taken;
            JUMP_JAL:    redirect_o = 1'b1;
            JUMP_JALR:   redirect_o = 1'b1;
            default:     redirect_o = 1'b0;
        endcase
    end

    // jalr target is rs1 + imm from the alu with bit 0 dropped
    assign target_o = (jump_i == JUMP_JALR) ?
                      {alu_result_i[rv_ex_pkg::WORD_W-1:1], 1'b0} : (pc_i + imm_i);

endmodule

// ==== hdl/rv_ex_pkg.sv ====
// word width is fixed at 32 bits and the ctrl encodings must match the decode stage
package rv_ex_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

    // source of an alu operand
    typedef enum logic [1:0] {
        REG       = 2'd0,
        WB        = 2'd1,
        PC_OR_IMM = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic [1:0] alu_op;
        logic       op1_pc;
        logic       op2_imm;
        logic [1:0] jump;
        logic       dmem_store;
        logic [1:0] wr_mux;
        logic       csr_we;
    } ex_ctrl_t;

    // id/ex payload
    typedef struct packed {
        logic                  valid;
        logic [WORD_W-1:0]     pc;
        logic [WORD_W-1:0]     pc_plus;
        logic [WORD_W-1:0]     reg1_data;
        logic [WORD_W-1:0]     reg2_data;
        logic [REG_ADDR_W-1:0] reg1_addr;
        logic [REG_ADDR_W-1:0] reg2_addr;
        logic [REG_ADDR_W-1:0] wb_addr;
        logic [WORD_W-1:0]     imm;
        logic [2:0]            funct3;
        logic                  inst30;
        ex_ctrl_t              ctrl;
    } ex_req_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [WORD_W-1:0]     data;
    } wb_fwd_t;

    // ex/mem payload
    typedef struct packed {
        logic                  valid;
        logic [WORD_W-1:0]     alu_result;
        logic [WORD_W-1:0]     mem_wdata;
        logic [3:0]            dmem_we;
        logic                  store_misalign;
        logic [REG_ADDR_W-1:0] wb_addr;
        logic [1:0]            wr_mux;
        logic [WORD_W-1:0]     pc_plus;
        logic                  csr_we;
        logic [WORD_W-1:0]     csr_data;
    } ex_mem_t;

endpackage

// ==== hdl/store_lane.sv ====
// little-endian lanes; a misaligned sh or sw writes nothing and only raises misalign_o
`timescale 1ns/1ps

module store_lane (
    input  logic                         store_i,
    input  logic [2:0]                   funct3_i,
    input  logic [1:0]                   addr_lo_i,
    input  logic [rv_ex_pkg::WORD_W-1:0] data_i,
    output logic [3:0]                   we_o,
    output logic [rv_ex_pkg::WORD_W-1:0] wdata_o,
    output logic                         misalign_o
);

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    always_comb begin
        we_o       = 4'b0000;
        wdata_o    = data_i;
        misalign_o = 1'b0;
        if (store_i) begin
            case (funct3_i)
                F3_SB: begin
                    we_o    = 4'b0001 << addr_lo_i;
                    wdata_o = {4{data_i[7:0]}};
                end
                F3_SH: begin
                    wdata_o = {2{data_i[15:0]}};
                    if (addr_lo_i[0]) begin
                        misalign_o = 1'b1;
                    end else if (addr_lo_i[1]) begin
                        we_o = 4'b1100;
                    end else begin
                        we_o = 4'b0011;
                    end
                end
                F3_SW: begin
                    if (addr_lo_i != 2'b00) begin
                        misalign_o = 1'b1;
                    end else begin
                        we_o = 4'b1111;
                    end
                end
                default: begin
                    // not a store width, nothing written
                    we_o = 4'b0000;
                end
            endcase
        end
    end

endmodule

// ==== tb/ex_stage_tb.sv ====
// one request per clock, write-back is the only forwarding source and stall is driven directly
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int          N_ALU       = 64;
    localparam int          TEST_CYCLES = 8 + N_ALU + 4 + 7 + 12 + 34 + 5 + 6;
    localparam logic [31:0] LFSR_MASK   = 32'hD000_0001;

    logic                         clk;
    logic                         rst_n;
    logic                         stall;
    rv_ex_pkg::ex_req_t           req;
    rv_ex_pkg::wb_fwd_t           fwd;
    rv_ex_pkg::ex_mem_t           ex_mem;
    logic                         redirect;
    logic [31:0]                  redirect_pc;
    logic [31:0]                  lfsr;
    int                           errors;
    int                           checks;

    ex_stage_top uut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .stall_i       (stall),
        .req_i         (req),
        .fwd_i         (fwd),
        .ex_mem_o      (ex_mem),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    // rv32i integer semantics per alu class
    function automatic logic [31:0] alu_model(input logic [1:0] cls, input logic [2:0] f3,
                                              input logic i30, input logic [31:0] a,
                                              input logic [31:0] b);
        logic signed [31:0] sa;
        logic [4:0]         sh;
        sa = a;
        sh = b[4:0];
        if (cls == 2'b00) begin
            return a + b;
        end
        if (cls == 2'b01) begin
            return b;
        end
        case (f3)
            3'b000:  return (cls == 2'b10 && i30) ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (i30) begin
                    return sa >>> sh;
                end
                return a >> sh;
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic store_model(input logic [2:0] f3, input logic [1:0] off, input logic [31:0] d,
                               output logic [3:0] we, output logic [31:0] wd, output logic mis);
        we  = 4'b0000;
        wd  = d;
        mis = 1'b0;
        case (f3)
            3'b000: begin
                we = 4'b0001 << off;
                wd = {4{d[7:0]}};
            end
            3'b001: begin
                wd  = {2{d[15:0]}};
                mis = off[0];
                we  = off[0] ? 4'b0000 : (off[1] ? 4'b1100 : 4'b0011);
            end
            default: begin
                mis = (off != 2'b00);
                we  = mis ? 4'b0000 : 4'b1111;
            end
        endcase
    endtask

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic rv_ex_pkg::ex_req_t base_req();
        rv_ex_pkg::ex_req_t r;
        r         = '0;
        r.valid   = 1'b1;
        r.pc      = 32'h0000_1000;
        r.pc_plus = 32'h0000_1004;
        return r;
    endfunction

    // called at a falling edge, leaves time for the combinational outputs
    task automatic present(input rv_ex_pkg::ex_req_t r, input rv_ex_pkg::wb_fwd_t f);
        req = r;
        fwd = f;
        #1;
    endtask

    task automatic reset_clears_controls();
        check("valid", 32'd0, ex_mem.valid);
        check("dmem_we", 32'd0, ex_mem.dmem_we);
        check("csr_we", 32'd0, ex_mem.csr_we);
        check("store_misalign", 32'd0, ex_mem.store_misalign);
    endtask

    task automatic alu_ops();
        rv_ex_pkg::ex_req_t r;
        logic [31:0]        a;
        logic [31:0]        b;
        int                 combo;
        for (int i = 0; i < N_ALU + 4; i++) begin
            r     = base_req();
            combo = i % 32;
            rand_bits(32, a);
            rand_bits(32, b);
            r.funct3 = combo[2:0];
            r.inst30 = combo[3];
            if (i < N_ALU) begin
                r.ctrl.alu_op = combo[4] ? 2'b11 : 2'b10;
            end else begin
                r.ctrl.alu_op = (i % 2 == 0) ? 2'b00 : 2'b01;
            end
            r.ctrl.op2_imm = r.ctrl.alu_op[0];
            r.reg1_addr    = 5'd1;
            r.reg2_addr    = 5'd2;
            r.reg1_data    = a;
            // the unused b source carries a decoy value
            r.reg2_data    = r.ctrl.op2_imm ? ~b : b;
            r.imm          = r.ctrl.op2_imm ? b : ~b;
            present(r, '0);
            check("redirect", 32'd0, redirect);
            @(negedge clk);
            check("alu_result", alu_model(r.ctrl.alu_op, r.funct3, r.inst30, a, b),
                  ex_mem.alu_result);
        end
    endtask

    task automatic fwd_case(input logic [4:0] r1a, input logic [4:0] r2a, input logic op1_pc,
                            input logic op2_imm, input logic fwe, input logic [4:0] faddr);
        rv_ex_pkg::ex_req_t r;
        rv_ex_pkg::wb_fwd_t f;
        logic [31:0]        rs1v;
        logic [31:0]        rs2v;
        logic [31:0]        exp_a;
        logic [31:0]        exp_b;
        r = base_req();
        rand_bits(32, r.reg1_data);
        rand_bits(32, r.reg2_data);
        rand_bits(32, r.imm);
        rand_bits(32, f.data);
        r.reg1_addr       = r1a;
        r.reg2_addr       = r2a;
        r.funct3          = 3'b000;
        r.ctrl.op1_pc     = op1_pc;
        r.ctrl.op2_imm    = op2_imm;
        r.ctrl.jump       = 2'b01;
        r.ctrl.dmem_store = 1'b1;
        f.we              = fwe;
        f.addr            = faddr;
        // beq and sb ride along to see the forwarded register values
        rs1v  = (fwe && r1a == faddr && r1a != 5'd0) ? f.data : r.reg1_data;
        rs2v  = (fwe && r2a == faddr && r2a != 5'd0) ? f.data : r.reg2_data;
        exp_a = op1_pc ? r.pc : rs1v;
        exp_b = op2_imm ? r.imm : rs2v;
        present(r, f);
        check("redirect", branch_taken(3'b000, rs1v, rs2v), redirect);
        check("redirect_pc", r.pc + r.imm, redirect_pc);
        @(negedge clk);
        check("alu_result", exp_a + exp_b, ex_mem.alu_result);
        check("mem_wdata", {4{rs2v[7:0]}}, ex_mem.mem_wdata);
    endtask

    task automatic forwarding_paths();
        fwd_case(5'd5, 5'd6, 1'b0, 1'b0, 1'b1, 5'd5);
        fwd_case(5'd5, 5'd6, 1'b0, 1'b0, 1'b1, 5'd6);
        fwd_case(5'd5, 5'd5, 1'b0, 1'b0, 1'b1, 5'd5);
        fwd_case(5'd0, 5'd0, 1'b0, 1'b0, 1'b1, 5'd0);
        fwd_case(5'd5, 5'd6, 1'b0, 1'b0, 1'b0, 5'd5);
        fwd_case(5'd5, 5'd6, 1'b1, 1'b0, 1'b1, 5'd5);
        fwd_case(5'd5, 5'd6, 1'b0, 1'b1, 1'b1, 5'd6);
    endtask

    task automatic store_widths();
        rv_ex_pkg::ex_req_t r;
        logic [31:0]        base;
        logic [3:0]         we;
        logic [31:0]        wd;
        logic               mis;
        for (int i = 0; i < 12; i++) begin
            r = base_req();
            rand_bits(32, base);
            rand_bits(32, r.reg2_data);
            r.funct3          = (i < 4) ? 3'b000 : ((i < 8) ? 3'b001 : 3'b010);
            r.ctrl.dmem_store = 1'b1;
            r.ctrl.op2_imm    = 1'b1;
            r.reg1_addr       = 5'd3;
            r.reg2_addr       = 5'd4;
            r.reg1_data       = {base[31:2], 2'b00};
            r.imm             = i % 4;
            store_model(r.funct3, r.imm[1:0], r.reg2_data, we, wd, mis);
            present(r, '0);
            @(negedge clk);
            check("alu_result", r.reg1_data + r.imm, ex_mem.alu_result);
            check("dmem_we", we, ex_mem.dmem_we);
            check("store_misalign", mis, ex_mem.store_misalign);
            if (!mis) begin
                check("mem_wdata", wd, ex_mem.mem_wdata);
            end
        end
    endtask

    task automatic branch_case(input logic [1:0] jump, input logic [2:0] f3,
                               input logic [31:0] a, input logic [31:0] b);
        rv_ex_pkg::ex_req_t r;
        logic [31:0]        v;
        logic               exp_redirect;
        logic [31:0]        exp_pc;
        r = base_req();
        rand_bits(32, r.pc);
        rand_bits(12, v);
        r.pc[1:0]      = 2'b00;
        r.imm          = {{20{v[11]}}, v[11:1], (jump == 2'b11)};
        r.funct3       = f3;
        r.ctrl.jump    = jump;
        r.ctrl.op1_pc  = (jump != 2'b11);
        r.ctrl.op2_imm = 1'b1;
        r.reg1_addr    = 5'd7;
        r.reg2_addr    = 5'd8;
        r.reg1_data    = a;
        r.reg2_data    = b;
        exp_redirect   = (jump == 2'b01) ? branch_taken(f3, a, b) : (jump != 2'b00);
        exp_pc         = (jump == 2'b11) ? ((a + r.imm) & ~32'd1) : (r.pc + r.imm);
        present(r, '0);
        check("redirect", exp_redirect, redirect);
        check("redirect_pc", exp_pc, redirect_pc);
        @(negedge clk);
    endtask

    task automatic branches_and_jumps();
        logic [31:0] a;
        logic [31:0] b;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            branch_case(2'b01, f[2:0], 32'h8000_0000, 32'h7fff_ffff);
            branch_case(2'b01, f[2:0], 32'hffff_ffff, 32'h0000_0001);
            branch_case(2'b01, f[2:0], 32'h1234_5678, 32'h1234_5678);
            rand_bits(32, a);
            rand_bits(32, b);
            branch_case(2'b01, f[2:0], a, b);
            branch_case(2'b01, f[2:0], b, a);
        end
        branch_case(2'b10, 3'b000, a, b);
        branch_case(2'b10, 3'b000, b, a);
        branch_case(2'b11, 3'b000, 32'h0000_2000, b);
        branch_case(2'b11, 3'b000, a & ~32'd1, b);
    endtask

    task automatic csr_case(input logic [2:0] f3, input logic fwd_rs1);
        rv_ex_pkg::ex_req_t r;
        rv_ex_pkg::wb_fwd_t f;
        logic [31:0]        v;
        logic [31:0]        rs1v;
        logic [31:0]        exp;
        r = base_req();
        f = '0;
        rand_bits(32, r.reg1_data);
        rand_bits(32, r.imm);
        rand_bits(32, r.pc_plus);
        rand_bits(32, f.data);
        rand_bits(7, v);
        r.wb_addr     = v[4:0];
        r.ctrl.wr_mux = v[6:5];
        r.reg1_addr   = 5'd9;
        r.funct3      = f3;
        r.ctrl.csr_we = 1'b1;
        f.we          = fwd_rs1;
        f.addr        = 5'd9;
        rs1v = fwd_rs1 ? f.data : r.reg1_data;
        exp  = (f3 == 3'b001) ? rs1v : ((f3 == 3'b101) ? r.imm : 32'd0);
        present(r, f);
        @(negedge clk);
        check("csr_data", exp, ex_mem.csr_data);
        check("csr_we", 32'd1, ex_mem.csr_we);
        check("wb_addr", r.wb_addr, ex_mem.wb_addr);
        check("wr_mux", r.ctrl.wr_mux, ex_mem.wr_mux);
        check("pc_plus", r.pc_plus, ex_mem.pc_plus);
        check("valid", 32'd1, ex_mem.valid);
    endtask

    task automatic csr_operand();
        csr_case(3'b001, 1'b0);
        csr_case(3'b001, 1'b1);
        csr_case(3'b101, 1'b0);
        csr_case(3'b010, 1'b0);
        csr_case(3'b110, 1'b1);
    endtask

    task automatic bubble_and_stall();
        rv_ex_pkg::ex_req_t r;
        rv_ex_pkg::ex_mem_t held;
        // bubble that would store, write a csr and jump
        r                 = base_req();
        r.valid           = 1'b0;
        r.funct3          = 3'b010;
        r.ctrl.dmem_store = 1'b1;
        r.ctrl.csr_we     = 1'b1;
        r.ctrl.jump       = 2'b10;
        present(r, '0);
        check("redirect", 32'd0, redirect);
        @(negedge clk);
        check("valid", 32'd0, ex_mem.valid);
        check("dmem_we", 32'd0, ex_mem.dmem_we);
        check("csr_we", 32'd0, ex_mem.csr_we);
        r.valid        = 1'b1;
        r.ctrl.jump    = 2'b00;
        r.ctrl.op2_imm = 1'b1;
        r.reg1_data    = 32'h0000_2000;
        r.reg2_data    = 32'hcafe_f00d;
        r.wb_addr      = 5'd4;
        present(r, '0);
        @(negedge clk);
        check("dmem_we", 32'hf, ex_mem.dmem_we);
        held  = ex_mem;
        stall = 1'b1;
        r             = base_req();
        r.ctrl.jump   = 2'b10;
        r.wb_addr     = 5'd17;
        present(r, '0);
        check("redirect", 32'd0, redirect);
        repeat (2) @(negedge clk);
        check("valid", held.valid, ex_mem.valid);
        check("alu_result", held.alu_result, ex_mem.alu_result);
        check("mem_wdata", held.mem_wdata, ex_mem.mem_wdata);
        check("dmem_we", held.dmem_we, ex_mem.dmem_we);
        check("wb_addr", held.wb_addr, ex_mem.wb_addr);
        check("csr_we", held.csr_we, ex_mem.csr_we);
        stall = 1'b0;
        #1;
        check("redirect", 32'd1, redirect);
        @(negedge clk);
        check("wb_addr", 32'd17, ex_mem.wb_addr);
        check("dmem_we", 32'd0, ex_mem.dmem_we);
    endtask

    initial begin
        #(TEST_CYCLES * 8 + 400);
        $display("timeout: tests still running after %0d cycles", TEST_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        lfsr   = 32'd6;
        rst_n  = 1'b0;
        stall  = 1'b0;
        fwd    = '0;
        // a live store with a csr write sits at the input during reset
        req                 = base_req();
        req.funct3          = 3'b010;
        req.ctrl.dmem_store = 1'b1;
        req.ctrl.csr_we     = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_clears_controls();
        alu_ops();
        forwarding_paths();
        store_widths();
        branches_and_jumps();
        csr_operand();
        bubble_and_stall();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
